// File: source/exu_pkg.sv
package exu_pkg;

  // alu operation codes, {funct7[5], funct3} style
  localparam int alu_op_width = 4;

  localparam logic [alu_op_width-1:0] alu_add  = 4'b0000;
  localparam logic [alu_op_width-1:0] alu_sub  = 4'b1000;
  localparam logic [alu_op_width-1:0] alu_sll  = 4'b0001;
  localparam logic [alu_op_width-1:0] alu_slt  = 4'b0010;
  localparam logic [alu_op_width-1:0] alu_sltu = 4'b0011;
  localparam logic [alu_op_width-1:0] alu_xor  = 4'b0100;
  localparam logic [alu_op_width-1:0] alu_srl  = 4'b0101;
  localparam logic [alu_op_width-1:0] alu_sra  = 4'b1101;
  localparam logic [alu_op_width-1:0] alu_or   = 4'b0110;
  localparam logic [alu_op_width-1:0] alu_and  = 4'b0111;
  // other codes give zero

  // operand pair select
  localparam int src_sel_width = 2;

  localparam logic [src_sel_width-1:0] src_rs1_rs2 = 2'b00;  // a=rs1, b=rs2
  localparam logic [src_sel_width-1:0] src_rs1_imm = 2'b01;  // a=rs1, b=imm
  localparam logic [src_sel_width-1:0] src_pc_4    = 2'b10;  // return addr
  localparam logic [src_sel_width-1:0] src_pc_imm  = 2'b11;  // auipc / jal target

  // branch funct3
  localparam logic [2:0] br_beq  = 3'b000;
  localparam logic [2:0] br_bne  = 3'b001;
  localparam logic [2:0] br_blt  = 3'b100;
  localparam logic [2:0] br_bge  = 3'b101;
  localparam logic [2:0] br_bltu = 3'b110;
  localparam logic [2:0] br_bgeu = 3'b111;
  // 010 and 011 are not branches

endpackage

// File: source/exu_key_mux.sv
`timescale 1ns/1ps

module exu_key_mux #(
  parameter int  NR_KEY    = 4,
  parameter int  KEY_LEN   = 2,
  parameter type payload_t = logic [31:0]
) (
  input  logic [KEY_LEN-1:0] key,
  input  logic [KEY_LEN-1:0] keys [NR_KEY],
  input  payload_t           values [NR_KEY],
  input  payload_t           default_out,
  output payload_t           out
);

  logic hit;  // a key already matched

  // first match in table order wins
  always_comb begin
    out = default_out;
    hit = 1'b0;
    for (int i = 0; i < NR_KEY; i++) begin
      if (!hit && (keys[i] == key)) begin
        out = values[i];
        hit = 1'b1;
      end
    end
  end

endmodule

// File: source/exu_alu.sv
`timescale 1ns/1ps

module exu_alu #(
  parameter int DATA_WIDTH = 32
) (
  input  logic [exu_pkg::alu_op_width-1:0] alu_op,
  input  logic [DATA_WIDTH-1:0]            alu_a,
  input  logic [DATA_WIDTH-1:0]            alu_b,
  output logic [DATA_WIDTH-1:0]            alu_result
);

  logic [DATA_WIDTH-1:0] sum;
  logic [DATA_WIDTH:0]   diff;       // extra bit holds the borrow
  logic                  borrow;     // a < b unsigned
  logic                  lt_signed;  // a < b signed
  logic [4:0]            shamt;

  assign sum    = alu_a + alu_b;
  assign diff   = {1'b0, alu_a} - {1'b0, alu_b};
  assign borrow = diff[DATA_WIDTH];
  assign shamt  = alu_b[4:0];

  // on sign mismatch the negative operand is smaller
  assign lt_signed = (alu_a[DATA_WIDTH-1] ^ alu_b[DATA_WIDTH-1]) ?
                     alu_a[DATA_WIDTH-1] : diff[DATA_WIDTH-1];

  always_comb begin
    case (alu_op)
      exu_pkg::alu_add: begin
        alu_result = sum;
      end
      exu_pkg::alu_sub: begin
        alu_result = diff[DATA_WIDTH-1:0];
      end
      exu_pkg::alu_sll: begin
        alu_result = alu_a << shamt;
      end
      exu_pkg::alu_slt: begin
        alu_result = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
      end
      exu_pkg::alu_sltu: begin
        alu_result = {{(DATA_WIDTH-1){1'b0}}, borrow};
      end
      exu_pkg::alu_xor: begin
        alu_result = alu_a ^ alu_b;
      end
      exu_pkg::alu_srl: begin
        alu_result = alu_a >> shamt;
      end
      exu_pkg::alu_sra: begin
        alu_result = $signed(alu_a) >>> shamt;  // keeps sign bit
      end
      exu_pkg::alu_or: begin
        alu_result = alu_a | alu_b;
      end
      exu_pkg::alu_and: begin
        alu_result = alu_a & alu_b;
      end
      default: begin
        alu_result = '0;
      end
    endcase
  end

endmodule

// File: source/exu_branch_cmp.sv
`timescale 1ns/1ps

module exu_branch_cmp #(
  parameter int DATA_WIDTH = 32
) (
  input  logic [2:0]            funct3,
  input  logic [DATA_WIDTH-1:0] alu_a,
  input  logic [DATA_WIDTH-1:0] alu_b,
  output logic                  taken
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (alu_a == alu_b);
  assign lt_s = ($signed(alu_a) < $signed(alu_b));
  assign lt_u = (alu_a < alu_b);

  always_comb begin
    case (funct3)
      exu_pkg::br_beq: begin
        taken = eq;
      end
      exu_pkg::br_bne: begin
        taken = ~eq;
      end
      exu_pkg::br_blt: begin
        taken = lt_s;
      end
      exu_pkg::br_bge: begin
        taken = ~lt_s;
      end
      exu_pkg::br_bltu: begin
        taken = lt_u;
      end
      exu_pkg::br_bgeu: begin
        taken = ~lt_u;
      end
      default: begin
        taken = 1'b0;  // not a branch encoding
      end
    endcase
  end

endmodule

// File: source/exu_top.sv
`timescale 1ns/1ps

module exu_top #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             in_valid,
  input  logic [DATA_WIDTH-1:0]            pc,
  input  logic [DATA_WIDTH-1:0]            src1,
  input  logic [DATA_WIDTH-1:0]            src2,
  input  logic [DATA_WIDTH-1:0]            imm,
  input  logic [exu_pkg::alu_op_width-1:0] alu_op,
  input  logic [exu_pkg::src_sel_width-1:0] src_sel,
  input  logic                             branch,
  input  logic [2:0]                       funct3,
  output logic                             out_valid,
  output logic [DATA_WIDTH-1:0]            result,
  output logic                             zero_flag
);

  typedef logic [2*DATA_WIDTH-1:0] pair_t;  // {alu_a, alu_b}
  typedef logic [DATA_WIDTH-1:0]   word_t;

  localparam word_t pc_step = word_t'(4);

  logic [exu_pkg::src_sel_width-1:0] src_keys [4];
  pair_t                             src_vals [4];
  logic [3:0]                        br_keys  [6];
  word_t                             br_vals  [6];

  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t taken_word;
  word_t exu_result;
  logic  taken;

  assign src_keys = '{exu_pkg::src_rs1_rs2, exu_pkg::src_rs1_imm,
                      exu_pkg::src_pc_4, exu_pkg::src_pc_imm};
  assign src_vals = '{{src1, src2}, {src1, imm}, {pc, pc_step}, {pc, imm}};

  exu_key_mux #(
    .NR_KEY    (4),
    .KEY_LEN   (exu_pkg::src_sel_width),
    .payload_t (pair_t)
  ) operand_sel (
    .key         (src_sel),
    .keys        (src_keys),
    .values      (src_vals),
    .default_out (pair_t'('0)),
    .out         ({alu_a, alu_b})
  );

  exu_alu #(
    .DATA_WIDTH (DATA_WIDTH)
  ) alu_inst (
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_result (alu_result)
  );

  exu_branch_cmp #(
    .DATA_WIDTH (DATA_WIDTH)
  ) branch_cmp_inst (
    .funct3 (funct3),
    .alu_a  (alu_a),
    .alu_b  (alu_b),
    .taken  (taken)
  );

  // branch decision lands in bit 0
  assign taken_word = {{(DATA_WIDTH-1){1'b0}}, taken};
  assign br_keys = '{{1'b1, exu_pkg::br_beq}, {1'b1, exu_pkg::br_bne},
                     {1'b1, exu_pkg::br_blt}, {1'b1, exu_pkg::br_bge},
                     {1'b1, exu_pkg::br_bltu}, {1'b1, exu_pkg::br_bgeu}};
  assign br_vals = '{taken_word, taken_word, taken_word,
                     taken_word, taken_word, taken_word};

  exu_key_mux #(
    .NR_KEY    (6),
    .KEY_LEN   (4),
    .payload_t (word_t)
  ) result_sel (
    .key         ({branch, funct3}),
    .keys        (br_keys),
    .values      (br_vals),
    .default_out (alu_result),  // non-branch or unused funct3
    .out         (exu_result)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
      zero_flag <= 1'b1;  // matches cleared result
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        result    <= exu_result;
        zero_flag <= ~(|exu_result);
      end
    end
  end

endmodule

// File: verification/exu_clk_gen.sv
`timescale 1ns/1ps

module exu_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;  // half period per phase
    end
  end

endmodule

// File: verification/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

  localparam int dw = 32;

  localparam logic [exu_pkg::alu_op_width-1:0] alu_ops [11] = '{
    exu_pkg::alu_add, exu_pkg::alu_sub, exu_pkg::alu_sll, exu_pkg::alu_slt,
    exu_pkg::alu_sltu, exu_pkg::alu_xor, exu_pkg::alu_srl, exu_pkg::alu_sra,
    exu_pkg::alu_or, exu_pkg::alu_and, 4'b1111
  };  // last one is an unused code
  localparam logic [2:0] br_codes [6] = '{
    exu_pkg::br_beq, exu_pkg::br_bne, exu_pkg::br_blt,
    exu_pkg::br_bge, exu_pkg::br_bltu, exu_pkg::br_bgeu
  };
  localparam logic [dw-1:0] edge_a [4] = '{32'h8000_0000, 32'h7fff_ffff, 32'h0, 32'hffff_ffff};
  localparam logic [dw-1:0] edge_b [4] = '{32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0};

  logic                              clk;
  logic                              arst_n;
  logic                              in_valid;
  logic [dw-1:0]                     pc;
  logic [dw-1:0]                     src1;
  logic [dw-1:0]                     src2;
  logic [dw-1:0]                     imm;
  logic [exu_pkg::alu_op_width-1:0]  alu_op;
  logic [exu_pkg::src_sel_width-1:0] src_sel;
  logic                              branch;
  logic [2:0]                        funct3;
  logic                              out_valid;
  logic [dw-1:0]                     result;
  logic                              zero_flag;
  logic                              exp_valid;
  logic [dw-1:0]                     exp_result;
  logic [31:0]                       lfsr;

  exu_clk_gen #(.PERIOD_NS (40)) clk_gen_inst (.clk (clk));

  exu_top #(
    .DATA_WIDTH (dw)
  ) exu_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .pc        (pc),
    .src1      (src1),
    .src2      (src2),
    .imm       (imm),
    .alu_op    (alu_op),
    .src_sel   (src_sel),
    .branch    (branch),
    .funct3    (funct3),
    .out_valid (out_valid),
    .result    (result),
    .zero_flag (zero_flag)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois step to the right
  endfunction

  // expected word from the execute rules
  function automatic logic [dw-1:0] model_result(
    input logic [dw-1:0]                     pc_v,
    input logic [dw-1:0]                     s1,
    input logic [dw-1:0]                     s2,
    input logic [dw-1:0]                     imm_v,
    input logic [exu_pkg::alu_op_width-1:0]  op,
    input logic [exu_pkg::src_sel_width-1:0] sel,
    input logic                              br,
    input logic [2:0]                        f3
  );
    logic [dw-1:0] a;
    logic [dw-1:0] b;
    logic [4:0]    sh;
    logic          cond;
    a = (sel == exu_pkg::src_pc_4 || sel == exu_pkg::src_pc_imm) ? pc_v : s1;
    case (sel)
      exu_pkg::src_rs1_rs2: b = s2;
      exu_pkg::src_pc_4:    b = dw'(4);
      default:              b = imm_v;
    endcase
    if (br && (f3[2] || !f3[1])) begin  // 010 and 011 fall through to the alu
      case (f3)
        exu_pkg::br_beq:  cond = (a == b);
        exu_pkg::br_bne:  cond = (a != b);
        exu_pkg::br_blt:  cond = ($signed(a) < $signed(b));
        exu_pkg::br_bge:  cond = ($signed(a) >= $signed(b));
        exu_pkg::br_bltu: cond = (a < b);
        default:          cond = (a >= b);
      endcase
      return {{(dw-1){1'b0}}, cond};
    end
    sh = b[4:0];
    case (op)
      exu_pkg::alu_add:  return a + b;
      exu_pkg::alu_sub:  return a - b;
      exu_pkg::alu_sll:  return a << sh;
      exu_pkg::alu_slt:  return {{(dw-1){1'b0}}, ($signed(a) < $signed(b))};
      exu_pkg::alu_sltu: return {{(dw-1){1'b0}}, (a < b)};
      exu_pkg::alu_xor:  return a ^ b;
      exu_pkg::alu_srl:  return a >> sh;
      exu_pkg::alu_sra:  return a[dw-1] ? ~((~a) >> sh) : (a >> sh);
      exu_pkg::alu_or:   return a | b;
      exu_pkg::alu_and:  return a & b;
      default:           return '0;
    endcase
  endfunction

  task automatic report_mismatch(
    input string       name,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    $display("ERROR %s expected %h actual %h", name, expected, actual);
    $display("Something failed");
    $fatal(1, "wrong value on %s", name);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "%s", what);
  endtask

  task automatic draw(input int nbits, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic send(
    input logic [dw-1:0] pc_v,
    input logic [dw-1:0] s1,
    input logic [dw-1:0] s2,
    input logic [dw-1:0] imm_v,
    input logic [3:0]    op,
    input logic [1:0]    sel,
    input logic          br,
    input logic [2:0]    f3
  );
    @(posedge clk);
    #2;
    in_valid = 1'b1;
    pc       = pc_v;
    src1     = s1;
    src2     = s2;
    imm      = imm_v;
    alu_op   = op;
    src_sel  = sel;
    branch   = br;
    funct3   = f3;
  endtask

  task automatic send_random(
    input logic [3:0] op,
    input logic [1:0] sel,
    input logic       br,
    input logic [2:0] f3
  );
    logic [31:0] p;
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] im;
    draw(dw, p);
    draw(dw, s1);
    draw(dw, s2);
    draw(dw, im);
    send(p, s1, s2, im, op, sel, br, f3);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      in_valid = 1'b0;
      draw(dw, pc);  // fresh operands that must not reach the output
      draw(dw, src1);
      draw(dw, src2);
      draw(dw, imm);
    end
  endtask

  // holds while in_valid is low
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_valid  <= 1'b0;
      exp_result <= '0;
    end else begin
      exp_valid <= in_valid;
      if (in_valid) begin
        exp_result <= model_result(pc, src1, src2, imm, alu_op, src_sel, branch, funct3);
      end
    end
  end

  valid_check: assert property (@(posedge clk) out_valid == exp_valid)
    else report_mismatch("out_valid", {31'b0, $sampled(exp_valid)}, {31'b0, $sampled(out_valid)});
  result_check: assert property (@(posedge clk) result == exp_result)
    else report_mismatch("result", $sampled(exp_result), $sampled(result));
  zero_check: assert property (@(posedge clk) zero_flag == (exp_result == '0))
    else report_mismatch("zero_flag", {31'b0, $sampled(exp_result) == '0},
                         {31'b0, $sampled(zero_flag)});

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    int          waited;
    lfsr     = 32'd34;
    arst_n   = 1'b1;
    in_valid = 1'b0;
    pc       = '0;
    src1     = '0;
    src2     = '0;
    imm      = '0;
    alu_op   = '0;
    src_sel  = '0;
    branch   = 1'b0;
    funct3   = '0;
    #1 arst_n = 1'b0;
    repeat (16) @(posedge clk);
    #2 arst_n = 1'b1;
    idle(3);
    send_random(exu_pkg::alu_add, exu_pkg::src_rs1_rs2, 1'b0, 3'b000);  // lone strobe
    idle(2);
    repeat (5) send_random(exu_pkg::alu_xor, exu_pkg::src_rs1_rs2, 1'b0, 3'b000);
    idle(1);
    for (int k = 0; k < 11; k++) begin
      repeat (16) send_random(alu_ops[k], exu_pkg::src_rs1_rs2, 1'b0, 3'b000);
    end
    repeat (8) begin
      draw(dw, a);
      draw(5, r);
      send('0, a | 32'h8000_0000, {27'b0, r[4:0]}, '0, exu_pkg::alu_sra,
           exu_pkg::src_rs1_rs2, 1'b0, 3'b000);
    end
    send('0, 32'h8000_0000, 32'd31, '0, exu_pkg::alu_sra, exu_pkg::src_rs1_rs2, 1'b0, 3'b000);
    send('0, 32'hf000_0001, 32'd31, '0, exu_pkg::alu_sll, exu_pkg::src_rs1_rs2, 1'b0, 3'b000);
    repeat (12) begin
      draw(4, r);
      send_random(r[3:0], exu_pkg::src_rs1_imm, 1'b0, 3'b000);
    end
    repeat (8) send_random(exu_pkg::alu_add, exu_pkg::src_pc_4, 1'b0, 3'b000);
    repeat (8) send_random(exu_pkg::alu_add, exu_pkg::src_pc_imm, 1'b0, 3'b000);
    for (int k = 0; k < 6; k++) begin
      repeat (8) send_random(exu_pkg::alu_add, exu_pkg::src_rs1_rs2, 1'b1, br_codes[k]);
      draw(dw, a);
      send('0, a, a, '0, exu_pkg::alu_add, exu_pkg::src_rs1_rs2, 1'b1, br_codes[k]);
      for (int j = 0; j < 4; j++) begin
        send('0, edge_a[j], edge_b[j], '0, exu_pkg::alu_sub, exu_pkg::src_rs1_rs2,
             1'b1, br_codes[k]);
      end
    end
    repeat (6) begin
      draw(4, r);
      send_random(r[3:0], exu_pkg::src_rs1_rs2, 1'b1, 3'b010);
      draw(4, r);
      send_random(r[3:0], exu_pkg::src_rs1_rs2, 1'b1, 3'b011);
    end
    repeat (4) begin
      draw(dw, a);
      send('0, a, a, '0, exu_pkg::alu_sub, exu_pkg::src_rs1_rs2, 1'b0, 3'b000);  // zero result
    end
    idle(1);
    waited = 0;
    while (out_valid && waited < 10) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (out_valid) begin
      report_failure("timeout waiting for out_valid to drop after the last input");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: filelist.f
source/exu_pkg.sv
source/exu_key_mux.sv
source/exu_alu.sv
source/exu_branch_cmp.sv
source/exu_top.sv
verification/exu_clk_gen.sv
verification/exu_tb.sv

// File: run.sh
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module exu_tb \
  -Mdir obj_dir -o exu_sim \
  && ./obj_dir/exu_sim \
  || { echo "simulation did not pass"; exit 1; }
exit 0
